/* filelist.f */
+incdir+rtl
rtl/mul_pkg.sv
rtl/csa_row.sv
rtl/cpa_stage.sv
rtl/mul_top.sv
tests/mul_assertions.sv
tests/mul_tb.sv

/* tests/mul_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mul_consts.svh"

module mul_tb;

   localparam int CLK_PERIOD = 40;
   localparam int RST_CYCLES = 3;
   localparam int LAT        = `MUL_LATENCY;

   localparam int QUIET_CYCLES = 5;
   localparam int N_CORNER     = 14;
   localparam int N_STREAM     = 200;
   localparam int N_GAPS       = 160;
   localparam int GAP_PAUSE    = 5;
   localparam int N_BURST      = 6;
   localparam int N_AFTER      = 8;
   localparam int DRAIN        = LAT + 2;
   localparam int FLUSH_IDLE   = LAT + 4;
   localparam int MARGIN       = 40;

   localparam int STIM_CYCLES = RST_CYCLES + QUIET_CYCLES
                              + N_CORNER + DRAIN
                              + N_STREAM + DRAIN
                              + N_GAPS + GAP_PAUSE + DRAIN
                              + N_BURST + RST_CYCLES + 1 + FLUSH_IDLE
                              + N_AFTER + DRAIN;

   localparam int WATCHDOG_CYCLES = STIM_CYCLES + LAT + MARGIN;

   // one expected result and the cycle its pair was sampled in
   typedef struct packed {
      mul_pkg::product_t prod;
      logic [31:0]       edge_no;
   } expect_t;

   logic              clk = 1'b0;
   logic              rst_n;
   logic              en;
   mul_pkg::operand_t a;
   mul_pkg::operand_t b;
   mul_pkg::product_t p;
   logic              p_valid;

   integer      seed;
   logic [31:0] coin;

   expect_t exp_q[$];
   int      edge_cnt;
   int      accepted_cnt;
   int      result_cnt;
   int      max_depth;

   mul_pkg::product_t last_exp;

   int value_errors;
   int protocol_errors;

   mul_top i_dut (
      .clk     (clk),
      .rst_n   (rst_n),
      .en      (en),
      .a       (a),
      .b       (b),
      .p       (p),
      .p_valid (p_valid)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // exact signed product, no wrap at 14 bits
   function automatic mul_pkg::product_t ref_product(
      input mul_pkg::operand_t x,
      input mul_pkg::operand_t y
   );
      int xi;
      int yi;
      xi = x;
      yi = y;
      return mul_pkg::product_t'(xi * yi);
   endfunction

   task automatic check_value(
      input string              what,
      input logic signed [31:0] got,
      input logic signed [31:0] exp
   );
      if (got !== exp) begin
         $display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
         value_errors++;
      end
   endtask

   task automatic drive(input logic e, input int x, input int y);
      @(negedge clk);
      en <= e;
      a  <= mul_pkg::operand_t'(x);
      b  <= mul_pkg::operand_t'(y);
   endtask

   task automatic drive_random(input logic e);
      logic [31:0] r;
      r = $random(seed);
      drive(e, r[6:0], r[14:8]);
   endtask

   task automatic idle(input int n);
      repeat (n) drive(1'b0, 0, 0);
   endtask

   task automatic apply_reset();
      @(negedge clk);
      rst_n <= 1'b0;
      en    <= 1'b0;
      repeat (RST_CYCLES) @(negedge clk);
      rst_n <= 1'b1;
   endtask

   // let the pipeline empty, then look between edges
   task automatic drain(input int n);
      idle(n);
      #(CLK_PERIOD / 4);
      if (exp_q.size() != 0) begin
         $display("%0t: %0d accepted pairs never produced a result",
                  $time, exp_q.size());
         protocol_errors++;
      end
      check_value("result count", result_cnt, accepted_cnt);
   endtask

   // sample accepted pairs, tagged with the current cycle
   always @(posedge clk) begin
      if (!rst_n) begin
         exp_q.delete();
         accepted_cnt = 0;
      end else if (en) begin
         exp_q.push_back('{prod: ref_product(a, b), edge_no: edge_cnt});
         accepted_cnt++;
      end
      edge_cnt++;
   end

   // compare outputs mid-cycle
   always @(negedge clk) begin : compare
      expect_t entry;
      if (!rst_n) begin
         last_exp   = '0;
         result_cnt = 0;
         check_value("p_valid in reset", p_valid, 0);
         check_value("p in reset", p, 0);
      end else if (p_valid) begin
         result_cnt++;
         if (exp_q.size() == 0) begin
            $display("%0t: p_valid is high but no pair is in flight", $time);
            protocol_errors++;
         end else begin
            // pairs in the pipeline, this one included
            if (exp_q.size() > max_depth) begin
               max_depth = exp_q.size();
            end
            entry = exp_q.pop_front();
            check_value("product", p, entry.prod);
            check_value("latency", edge_cnt - int'(entry.edge_no), LAT);
            last_exp = entry.prod;
         end
      end else begin
         // gap cycle, p must hold
         check_value("held p", p, last_exp);
      end
   end

   initial begin
      rst_n           = 1'b0;
      en              = 1'b0;
      a               = '0;
      b               = '0;
      seed            = 8;
      edge_cnt        = 0;
      accepted_cnt    = 0;
      result_cnt      = 0;
      max_depth       = 0;
      last_exp        = '0;
      value_errors    = 0;
      protocol_errors = 0;
      $timeformat(-9, 0, " ns", 0);

      repeat (RST_CYCLES) @(negedge clk);
      rst_n <= 1'b1;

      // nothing may come out before the first pair
      drain(QUIET_CYCLES);

      // corner operands, back to back
      drive(1'b1, 0, 0);
      drive(1'b1, 0, 37);
      drive(1'b1, -45, 0);
      drive(1'b1, 0, -64);
      drive(1'b1, 63, 0);
      drive(1'b1, 1, 1);
      drive(1'b1, 1, -1);
      drive(1'b1, -1, 1);
      drive(1'b1, -1, -1);
      drive(1'b1, 63, 63);
      drive(1'b1, -64, 63);
      drive(1'b1, 63, -64);
      drive(1'b1, -64, -64);
      drive(1'b1, -64, 1);
      drain(DRAIN);

      // en high every cycle
      repeat (N_STREAM) drive_random(1'b1);
      drain(DRAIN);
      check_value("pairs in flight", max_depth, LAT);

      // random gaps with a longer pause in the middle
      repeat (N_GAPS / 2) begin
         coin = $random(seed);
         drive_random(coin[1:0] != 2'b00);
      end
      idle(GAP_PAUSE);
      repeat (N_GAPS - N_GAPS / 2) begin
         coin = $random(seed);
         drive_random(coin[0]);
      end
      drain(DRAIN);

      // reset with pairs in flight
      repeat (N_BURST) drive_random(1'b1);
      apply_reset();
      drain(FLUSH_IDLE);
      repeat (N_AFTER) drive_random(1'b1);
      drain(DRAIN);

      $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
      if (value_errors + protocol_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("ERRORS FOUND");
      $finish;
   end

endmodule

`default_nettype wire

/* tests/mul_assertions.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mul_consts.svh"

module mul_assertions (
   input logic              clk,
   input logic              rst_n,
   input logic              en,
   input mul_pkg::product_t p,
   input logic              p_valid
);

   localparam int LAT = `MUL_LATENCY;

   // rising edges since reset release, saturating
   int unsigned run_cycles;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         run_cycles <= 0;
      end else if (run_cycles < LAT) begin
         run_cycles <= run_cycles + 1;
      end
   end

   // checked mid-cycle where both are settled
   a_no_valid_in_reset : assert property (
      @(negedge clk) !rst_n |-> !p_valid
   ) else $error("p_valid is high while reset is asserted");

   a_valid_follows_en : assert property (
      @(posedge clk) disable iff (!rst_n)
      (run_cycles >= LAT) |-> (p_valid == $past(en, LAT))
   ) else $error("p_valid does not follow en by the pipeline latency");

   a_p_known : assert property (
      @(posedge clk) disable iff (!rst_n)
      p_valid |-> !$isunknown(p)
   ) else $error("p holds unknown bits while p_valid is high");

endmodule

bind mul_top mul_assertions i_assertions (
   .clk     (clk),
   .rst_n   (rst_n),
   .en      (en),
   .p       (p),
   .p_valid (p_valid)
);

`default_nettype wire

/* rtl/mul_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mul_consts.svh"

module mul_top (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              en,
   input  mul_pkg::operand_t a,
   input  mul_pkg::operand_t b,
   output mul_pkg::product_t p,
   output logic              p_valid
);

   localparam int ROWS = `MUL_OP_WIDTH;

   // stage[k] feeds row k and stage[ROWS] feeds the adder
   mul_pkg::mul_stage_t stage [0:ROWS];

   // new pair enters with empty sum and carry
   assign stage[0] = '{
      valid: en,
      a:     a,
      b:     b,
      sum:   '0,
      carry: '0
   };

   for (genvar k = 0; k < ROWS; k++) begin : g_row
      csa_row #(
         .ROW_IDX (k)
      ) i_row (
         .clk       (clk),
         .rst_n     (rst_n),
         .stage_in  (stage[k]),
         .stage_out (stage[k+1])
      );
   end

   cpa_stage i_cpa (
      .clk      (clk),
      .rst_n    (rst_n),
      .stage_in (stage[ROWS]),
      .p        (p),
      .p_valid  (p_valid)
   );

endmodule

`default_nettype wire

/* rtl/cpa_stage.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mul_consts.svh"

module cpa_stage (
   input  logic                clk,
   input  logic                rst_n,
   input  mul_pkg::mul_stage_t stage_in,
   output mul_pkg::product_t   p,
   output logic                p_valid
);

   localparam int PROD_W = `MUL_PROD_WIDTH;

   mul_pkg::product_t sum_res;
   logic [PROD_W-1:0] ripple;

   // ripple-carry chain over sum and carry
   assign ripple[0] = 1'b0;

   for (genvar i = 0; i < PROD_W; i++) begin : g_bit
      mul_pkg::fa_out_t fa;

      assign fa         = mul_pkg::full_add(stage_in.sum[i], stage_in.carry[i], ripple[i]);
      assign sum_res[i] = fa.s;

      // last carry out is beyond the product width
      if (i < PROD_W - 1) begin : g_chain
         assign ripple[i+1] = fa.c;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         p_valid <= 1'b0;
      end else begin
         p_valid <= stage_in.valid;
      end
   end

   // p holds the last product through gaps
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         p <= '0;
      end else if (stage_in.valid) begin
         p <= sum_res;
      end
   end

endmodule

`default_nettype wire

/* rtl/csa_row.sv */
`timescale 1ns/10ps
`default_nettype none

`include "mul_consts.svh"

module csa_row #(
   parameter int ROW_IDX = 0
) (
   input  logic                clk,
   input  logic                rst_n,
   input  mul_pkg::mul_stage_t stage_in,
   output mul_pkg::mul_stage_t stage_out
);

   localparam int OP_W   = `MUL_OP_WIDTH;
   localparam int PROD_W = `MUL_PROD_WIDTH;

   // sign bit of b has negative weight
   localparam bit TOP_ROW = (ROW_IDX == OP_W - 1);

   mul_pkg::product_t   a_ext;
   mul_pkg::product_t   pp;
   mul_pkg::product_t   pp_term;
   logic                plus_one;
   mul_pkg::product_t   sum_next;
   mul_pkg::product_t   carry_next;
   mul_pkg::mul_stage_t stage_next;

   if (ROW_IDX < 0 || ROW_IDX >= OP_W) begin : g_bad_idx
      $error("csa_row: ROW_IDX %0d is not a bit of the operand", ROW_IDX);
   end

   assign a_ext = mul_pkg::sign_extend(stage_in.a);

   // a weighted by this bit of b
   assign pp = (a_ext << ROW_IDX) & {PROD_W{stage_in.b[ROW_IDX]}};

   // top row subtracts by inverting here and adding one at carry bit 0
   assign pp_term  = TOP_ROW ? ~pp : pp;
   assign plus_one = TOP_ROW ? 1'b1 : 1'b0;

   // one full adder per column
   always_comb begin
      mul_pkg::fa_out_t fa;
      carry_next    = '0;
      carry_next[0] = plus_one;
      for (int i = 0; i < PROD_W; i++) begin
         fa = mul_pkg::full_add(stage_in.sum[i], stage_in.carry[i], pp_term[i]);
         sum_next[i] = fa.s;
         // msb carry dropped since the sum is modulo 2**PROD_W
         if (i < PROD_W - 1) begin
            carry_next[i+1] = fa.c;
         end
      end
   end

   // operands and valid ride along unchanged
   always_comb begin
      stage_next       = stage_in;
      stage_next.sum   = sum_next;
      stage_next.carry = carry_next;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stage_out <= '0;
      end else begin
         stage_out <= stage_next;
      end
   end

endmodule

`default_nettype wire

/* rtl/mul_pkg.sv */
`default_nettype none

`include "mul_consts.svh"

package mul_pkg;

   // two's-complement operand
   typedef logic signed [`MUL_OP_WIDTH-1:0] operand_t;

   // exact product, also the width of the sum and carry vectors
   typedef logic signed [`MUL_PROD_WIDTH-1:0] product_t;

   // record handed from one pipeline stage to the next
   typedef struct packed {
      logic     valid;
      operand_t a;
      operand_t b;
      product_t sum;
      product_t carry;
   } mul_stage_t;

   // result of one full adder cell
   typedef struct packed {
      logic c;
      logic s;
   } fa_out_t;

   function automatic fa_out_t full_add(
      input logic x,
      input logic y,
      input logic z
   );
      fa_out_t r;
      r.s = x ^ y ^ z;
      r.c = (x & y) | (x & z) | (y & z);
      return r;
   endfunction

   // replicate the sign bit up to product width
   function automatic product_t sign_extend(input operand_t op);
      product_t r;
      r = {{(`MUL_PROD_WIDTH - `MUL_OP_WIDTH){op[`MUL_OP_WIDTH-1]}}, op};
      return r;
   endfunction

endpackage

`default_nettype wire

/* rtl/mul_consts.svh */
`ifndef MUL_CONSTS_SVH
`define MUL_CONSTS_SVH

// width of each signed operand
`define MUL_OP_WIDTH 7

// exact signed product width
`define MUL_PROD_WIDTH (2 * `MUL_OP_WIDTH)

// seven csa rows plus the final adder stage
`define MUL_LATENCY (`MUL_OP_WIDTH + 1)

`endif
